//--- source/flight_settings.svh
`ifndef FLIGHT_SETTINGS_SVH
`define FLIGHT_SETTINGS_SVH

// signed 12.4 fixed point for targets, measurements and commands
`define RATE_BIT_WIDTH 16
`define RATE_FRAC_BITS 4

// unsigned throttle and motor words
`define THROTTLE_BIT_WIDTH 12
`define MOTOR_BIT_WIDTH 12
`define MOTOR_MAX 4000

// one fifo entry: yaw, pitch, roll, throttle
`define ENTRY_BIT_WIDTH (3 * `RATE_BIT_WIDTH + `THROTTLE_BIT_WIDTH)

// pid scaling and integral clamp
`define GAIN_SHIFT 4
`define INTEG_LIMIT 8000
`define KP_DEFAULT 8'd12
`define KI_DEFAULT 8'd2
`define KP_YAW 8'd6
`define KI_YAW 8'd1

// entries buffered between controller and mixer
`define FIFO_DEPTH 4

`endif

//--- source/flight_pkg.sv
`default_nettype none

`include "flight_settings.svh"

package flight_pkg;

	// rate in deg/s, 12.4 two's complement
	typedef logic signed [`RATE_BIT_WIDTH-1:0] rate_t;

	// motor command, 0 up to MOTOR_MAX
	typedef logic [`MOTOR_BIT_WIDTH-1:0] motor_t;

	// throttle as given by the pilot side
	typedef logic [`THROTTLE_BIT_WIDTH-1:0] throttle_t;

	// cycle sequencer
	typedef enum logic [1:0] {
		// idle, accepts a start when the fifo has room
		WAITING,
		// one cycle of pid_start
		STARTING,
		// pids running
		ACTIVE,
		// done pulse and fifo push
		COMPLETE
	} bfc_state_e;

	// one axis controller
	typedef enum logic [1:0] {
		// after reset only
		IDLE,
		// latch saturated error
		CALC_ERROR,
		// update integral and output
		CALC_TERMS,
		// result held until next start
		DONE
	} pid_state_e;

endpackage

`default_nettype wire

//--- source/pid.sv
`timescale 1ns/1ps
`default_nettype none

`include "flight_settings.svh"

module pid #(
	parameter logic [7:0] KP = `KP_DEFAULT,
	parameter logic [7:0] KI = `KI_DEFAULT
) (
	input  logic              start_signal,
	input  logic              resetn,
	input  logic              pid_start,
	input  flight_pkg::rate_t target_rotation,
	input  flight_pkg::rate_t actual_rotation,
	output flight_pkg::rate_t rate_out,
	output logic              pid_active,
	output logic              pid_complete
);
	import flight_pkg::*;

	// room for gain products and their sum
	localparam int ACC_W = `RATE_BIT_WIDTH + 10;
	localparam logic signed [ACC_W-1:0] RATE_MAX = (1 << (`RATE_BIT_WIDTH - 1)) - 1;
	localparam logic signed [ACC_W-1:0] RATE_MIN = -(1 << (`RATE_BIT_WIDTH - 1));
	localparam logic signed [ACC_W-1:0] I_MAX = `INTEG_LIMIT;
	localparam logic signed [ACC_W-1:0] I_MIN = -`INTEG_LIMIT;

	pid_state_e state, next_state;

	// error and integral registers
	rate_t error_q;
	rate_t integ_q;
	rate_t integ_next;
	rate_t out_next;

	// wide intermediates
	logic signed [ACC_W-1:0] diff;
	logic signed [ACC_W-1:0] integ_sum;
	logic signed [ACC_W-1:0] p_term;
	logic signed [ACC_W-1:0] i_term;
	logic signed [ACC_W-1:0] acc;

	// clip a wide value into a rate word
	function automatic rate_t sat_rate(input logic signed [ACC_W-1:0] v);
		if (v > RATE_MAX)
			return rate_t'(RATE_MAX);
		else if (v < RATE_MIN)
			return rate_t'(RATE_MIN);
		else
			return rate_t'(v);
	endfunction

	// datapath, all combinational off the registers
	always_comb begin
		diff = target_rotation - actual_rotation;
		integ_sum = integ_q + error_q;
		// anti windup
		if (integ_sum > I_MAX)
			integ_next = rate_t'(I_MAX);
		else if (integ_sum < I_MIN)
			integ_next = rate_t'(I_MIN);
		else
			integ_next = rate_t'(integ_sum);
		// gains are unsigned, keep the product signed
		p_term = $signed({1'b0, KP}) * error_q;
		i_term = $signed({1'b0, KI}) * integ_next;
		acc = p_term + i_term;
		out_next = sat_rate(acc >>> `GAIN_SHIFT);
	end

	// next state
	always_comb begin
		next_state = state;
		case (state)
			IDLE, DONE: begin
				if (pid_start)
					next_state = CALC_ERROR;
			end
			CALC_ERROR: next_state = CALC_TERMS;
			CALC_TERMS: next_state = DONE;
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			state <= IDLE;
		else
			state <= next_state;
	end

	// integral survives between cycles
	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			integ_q <= '0;
		else if (state == CALC_TERMS)
			integ_q <= integ_next;
	end

	// error and result words
	always_ff @(posedge start_signal) begin
		if (state == CALC_ERROR)
			error_q <= sat_rate(diff);
		if (state == CALC_TERMS)
			rate_out <= out_next;
	end

	// status straight from the state
	assign pid_active = (state == CALC_ERROR) || (state == CALC_TERMS);
	assign pid_complete = (state == DONE);

endmodule

`default_nettype wire

//--- source/body_frame_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "flight_settings.svh"

module body_frame_controller (
	input  logic                        start_signal,
	input  logic                        resetn,
	input  logic                        cycle_start,
	input  logic                        fifo_full,
	input  flight_pkg::throttle_t       throttle,
	input  flight_pkg::rate_t           yaw_target,
	input  flight_pkg::rate_t           pitch_target,
	input  flight_pkg::rate_t           roll_target,
	input  flight_pkg::rate_t           yaw_rotation,
	input  flight_pkg::rate_t           pitch_rotation,
	input  flight_pkg::rate_t           roll_rotation,
	output logic                        cycle_ready,
	output logic                        cycle_done,
	output logic                        push,
	output logic [`ENTRY_BIT_WIDTH-1:0] push_data
);
	import flight_pkg::*;

	bfc_state_e state, next_state;

	// inputs held for the whole cycle
	throttle_t throttle_q;
	rate_t yaw_tgt_q, pitch_tgt_q, roll_tgt_q;
	rate_t yaw_act_q, pitch_act_q, roll_act_q;

	// pid results and status
	rate_t yaw_rate, pitch_rate, roll_rate;
	logic yaw_active, pitch_active, roll_active;
	logic yaw_complete, pitch_complete, roll_complete;
	logic pid_start;
	logic accept;
	logic all_done;

	// no new cycle while the fifo has no room
	assign cycle_ready = (state == WAITING) && !fifo_full;
	assign accept = cycle_ready && cycle_start;
	assign pid_start = (state == STARTING);
	assign all_done = yaw_complete && pitch_complete && roll_complete
		&& !(yaw_active || pitch_active || roll_active);

	always_comb begin
		next_state = state;
		case (state)
			WAITING: begin
				if (accept)
					next_state = STARTING;
			end
			STARTING: next_state = ACTIVE;
			ACTIVE: begin
				if (all_done)
					next_state = COMPLETE;
			end
			COMPLETE: next_state = WAITING;
			default: next_state = WAITING;
		endcase
	end

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			state <= WAITING;
		else
			state <= next_state;
	end

	// capture on the accepting edge
	always_ff @(posedge start_signal) begin
		if (accept) begin
			throttle_q <= throttle;
			yaw_tgt_q <= yaw_target;
			pitch_tgt_q <= pitch_target;
			roll_tgt_q <= roll_target;
			yaw_act_q <= yaw_rotation;
			pitch_act_q <= pitch_rotation;
			roll_act_q <= roll_rotation;
		end
	end

	// done pulse doubles as fifo write
	assign cycle_done = (state == COMPLETE);
	assign push = cycle_done;
	assign push_data = {yaw_rate, pitch_rate, roll_rate, throttle_q};

	// yaw runs softer gains
	pid #(.KP(`KP_YAW), .KI(`KI_YAW)) yaw_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_start(pid_start),
		.target_rotation(yaw_tgt_q),
		.actual_rotation(yaw_act_q),
		.rate_out(yaw_rate),
		.pid_active(yaw_active),
		.pid_complete(yaw_complete)
	);

	pid pitch_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_start(pid_start),
		.target_rotation(pitch_tgt_q),
		.actual_rotation(pitch_act_q),
		.rate_out(pitch_rate),
		.pid_active(pitch_active),
		.pid_complete(pitch_complete)
	);

	pid roll_pid (
		.start_signal(start_signal),
		.resetn(resetn),
		.pid_start(pid_start),
		.target_rotation(roll_tgt_q),
		.actual_rotation(roll_act_q),
		.rate_out(roll_rate),
		.pid_active(roll_active),
		.pid_complete(roll_complete)
	);

endmodule

`default_nettype wire

//--- source/rate_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "flight_settings.svh"

module rate_fifo #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic                        start_signal,
	input  logic                        resetn,
	input  logic                        push,
	input  logic [`ENTRY_BIT_WIDTH-1:0] push_data,
	input  logic                        pop,
	output logic [`ENTRY_BIT_WIDTH-1:0] pop_data,
	output logic                        full,
	output logic                        empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [`ENTRY_BIT_WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push, do_pop;

	// wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		else
			return p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign do_pop = pop && !empty;
	// a pop on a full fifo frees the slot being written
	assign do_push = push && (!full || do_pop);
	// head entry visible without a read strobe
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge start_signal) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

//--- source/motor_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "flight_settings.svh"

module motor_mixer (
	input  logic                        start_signal,
	input  logic                        resetn,
	input  logic                        empty,
	input  logic [`ENTRY_BIT_WIDTH-1:0] pop_data,
	input  logic                        motor_ready,
	output logic                        pop,
	output logic                        motor_valid,
	output flight_pkg::motor_t          motor0,
	output flight_pkg::motor_t          motor1,
	output flight_pkg::motor_t          motor2,
	output flight_pkg::motor_t          motor3
);
	import flight_pkg::*;

	// throttle plus three integer rates, with headroom
	localparam int MIX_W = `RATE_BIT_WIDTH + 2;

	rate_t yaw, pitch, roll;
	throttle_t thr;
	logic signed [MIX_W-1:0] t_s, y_s, p_s, r_s;
	logic signed [MIX_W-1:0] sum0, sum1, sum2, sum3;

	// limit to 0 .. MOTOR_MAX
	function automatic motor_t clamp_motor(input logic signed [MIX_W-1:0] v);
		if (v < 0)
			return '0;
		else if (v > `MOTOR_MAX)
			return motor_t'(`MOTOR_MAX);
		else
			return motor_t'(v);
	endfunction

	// same packing as the controller push
	assign {yaw, pitch, roll, thr} = pop_data;

	always_comb begin
		t_s = $signed({1'b0, thr});
		// drop the fraction bits
		y_s = yaw >>> `RATE_FRAC_BITS;
		p_s = pitch >>> `RATE_FRAC_BITS;
		r_s = roll >>> `RATE_FRAC_BITS;
		// quad x, front left / front right / rear right / rear left
		sum0 = t_s + p_s + r_s - y_s;
		sum1 = t_s + p_s - r_s + y_s;
		sum2 = t_s - p_s - r_s - y_s;
		sum3 = t_s - p_s + r_s + y_s;
	end

	// refill when the output slot is free or leaving this cycle
	assign pop = !empty && (!motor_valid || motor_ready);

	always_ff @(posedge start_signal or negedge resetn) begin
		if (!resetn)
			motor_valid <= 1'b0;
		else if (pop)
			motor_valid <= 1'b1;
		else if (motor_ready)
			motor_valid <= 1'b0;
	end

	// output words only move on a pop, so held under stall
	always_ff @(posedge start_signal) begin
		if (pop) begin
			motor0 <= clamp_motor(sum0);
			motor1 <= clamp_motor(sum1);
			motor2 <= clamp_motor(sum2);
			motor3 <= clamp_motor(sum3);
		end
	end

endmodule

`default_nettype wire

//--- source/rate_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "flight_settings.svh"

module rate_controller_top (
	input  logic                  start_signal,
	input  logic                  resetn,
	input  logic                  cycle_start,
	input  flight_pkg::throttle_t throttle,
	input  flight_pkg::rate_t     yaw_target,
	input  flight_pkg::rate_t     pitch_target,
	input  flight_pkg::rate_t     roll_target,
	input  flight_pkg::rate_t     yaw_rotation,
	input  flight_pkg::rate_t     pitch_rotation,
	input  flight_pkg::rate_t     roll_rotation,
	output logic                  cycle_ready,
	output logic                  cycle_done,
	input  logic                  motor_ready,
	output logic                  motor_valid,
	output flight_pkg::motor_t    motor0,
	output flight_pkg::motor_t    motor1,
	output flight_pkg::motor_t    motor2,
	output flight_pkg::motor_t    motor3
);
	// controller to fifo
	logic push;
	logic [`ENTRY_BIT_WIDTH-1:0] push_data;
	logic fifo_full;

	// fifo to mixer
	logic pop;
	logic [`ENTRY_BIT_WIDTH-1:0] pop_data;
	logic fifo_empty;

	body_frame_controller u_bfc (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.fifo_full(fifo_full),
		.throttle(throttle),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.yaw_rotation(yaw_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_rotation(roll_rotation),
		.cycle_ready(cycle_ready),
		.cycle_done(cycle_done),
		.push(push),
		.push_data(push_data)
	);

	rate_fifo #(.DEPTH(`FIFO_DEPTH)) u_fifo (
		.start_signal(start_signal),
		.resetn(resetn),
		.push(push),
		.push_data(push_data),
		.pop(pop),
		.pop_data(pop_data),
		.full(fifo_full),
		.empty(fifo_empty)
	);

	motor_mixer u_mixer (
		.start_signal(start_signal),
		.resetn(resetn),
		.empty(fifo_empty),
		.pop_data(pop_data),
		.motor_ready(motor_ready),
		.pop(pop),
		.motor_valid(motor_valid),
		.motor0(motor0),
		.motor1(motor1),
		.motor2(motor2),
		.motor3(motor3)
	);

endmodule

`default_nettype wire

//--- tests/rate_controller_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rate_controller_checker (
	input logic               start_signal,
	input logic               resetn,
	input logic               cycle_start,
	input logic               cycle_ready,
	input logic               cycle_done,
	input logic               fifo_full,
	input logic               motor_valid,
	input logic               motor_ready,
	input flight_pkg::motor_t motor0,
	input flight_pkg::motor_t motor1,
	input flight_pkg::motor_t motor2,
	input flight_pkg::motor_t motor3
);
	// failed assertions so far
	int unsigned fail_count = 0;

	// done pulse never stretches
	done_one_wide: assert property (@(posedge start_signal) disable iff (!resetn)
		cycle_done |=> !cycle_done)
	else begin
		fail_count++;
		$error("cycle_done high for more than one clock");
	end

	// stalled output keeps its words
	stall_stable: assert property (@(posedge start_signal) disable iff (!resetn)
		motor_valid && !motor_ready |=> motor_valid && $stable(motor0)
			&& $stable(motor1) && $stable(motor2) && $stable(motor3))
	else begin
		fail_count++;
		$error("motor outputs changed while stalled");
	end

	// starting, three pid clocks, complete
	done_latency: assert property (@(posedge start_signal) disable iff (!resetn)
		cycle_ready && cycle_start |-> ##5 cycle_done)
	else begin
		fail_count++;
		$error("cycle_done not 5 clocks after the accepted start");
	end

	// a start offered while the fifo is full launches nothing
	full_blocks_start: assert property (@(posedge start_signal) disable iff (!resetn)
		fifo_full && cycle_start |-> ##5 !cycle_done)
	else begin
		fail_count++;
		$error("start taken while the FIFO was full");
	end

endmodule

bind rate_controller_top rate_controller_checker u_checker (
	.start_signal(start_signal),
	.resetn(resetn),
	.cycle_start(cycle_start),
	.cycle_ready(cycle_ready),
	.cycle_done(cycle_done),
	.fifo_full(fifo_full),
	.motor_valid(motor_valid),
	.motor_ready(motor_ready),
	.motor0(motor0),
	.motor1(motor1),
	.motor2(motor2),
	.motor3(motor3)
);

`default_nettype wire

//--- tests/rate_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "flight_settings.svh"

module rate_controller_tb;
	import flight_pkg::*;

	localparam logic [31:0] SEED = 32'd8661;
	// cycles launched over all tests, 20 clocks of budget each
	localparam int TOTAL_CYCLES = 60;
	localparam int WATCHDOG_NS = TOTAL_CYCLES * 20 * 10 + 20000;
	localparam int RATE_HI = (1 << (`RATE_BIT_WIDTH - 1)) - 1;
	localparam int RATE_LO = -(1 << (`RATE_BIT_WIDTH - 1));

	// motor0 .. motor3 of one entry
	typedef motor_t [3:0] motor_quad_t;

	logic start_signal;
	logic resetn;
	logic cycle_start;
	throttle_t throttle;
	rate_t yaw_target, pitch_target, roll_target;
	rate_t yaw_rotation, pitch_rotation, roll_rotation;
	logic cycle_ready, cycle_done;
	logic motor_ready, motor_valid;
	motor_t motor0, motor1, motor2, motor3;

	// reference model state, one integral per axis
	int integ_yaw, integ_pitch, integ_roll;
	motor_quad_t expected_q[$];
	motor_quad_t last_motor;
	rate_t got_pitch;
	logic ready_random;
	logic [31:0] stim_state, ready_state;
	int errors;

	rate_controller_top UUT (
		.start_signal(start_signal),
		.resetn(resetn),
		.cycle_start(cycle_start),
		.throttle(throttle),
		.yaw_target(yaw_target),
		.pitch_target(pitch_target),
		.roll_target(roll_target),
		.yaw_rotation(yaw_rotation),
		.pitch_rotation(pitch_rotation),
		.roll_rotation(roll_rotation),
		.cycle_ready(cycle_ready),
		.cycle_done(cycle_done),
		.motor_ready(motor_ready),
		.motor_valid(motor_valid),
		.motor0(motor0),
		.motor1(motor1),
		.motor2(motor2),
		.motor3(motor3)
	);

	initial begin
		start_signal = 1'b0;
		forever #5 start_signal = ~start_signal;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int sat_rate(input int v);
		if (v > RATE_HI)
			return RATE_HI;
		else if (v < RATE_LO)
			return RATE_LO;
		return v;
	endfunction

	// one pid step, integral advanced in place
	function automatic int model_pid(input int kp, input int ki, input int tgt,
		input int act, inout int integ);
		int err;
		err = sat_rate(tgt - act);
		integ = integ + err;
		if (integ > `INTEG_LIMIT)
			integ = `INTEG_LIMIT;
		else if (integ < -`INTEG_LIMIT)
			integ = -`INTEG_LIMIT;
		return sat_rate((kp * err + ki * integ) >>> `GAIN_SHIFT);
	endfunction

	function automatic motor_t clamp_expected(input int v);
		if (v < 0)
			return '0;
		else if (v > `MOTOR_MAX)
			return motor_t'(`MOTOR_MAX);
		return motor_t'(v);
	endfunction

	// quad x mix on the integer part of each rate
	function automatic motor_quad_t expected_motors(input int thr, input int y,
		input int p, input int r);
		motor_quad_t q;
		int yi, pi, ri;
		yi = y >>> 4;
		pi = p >>> 4;
		ri = r >>> 4;
		q[0] = clamp_expected(thr + pi + ri - yi);
		q[1] = clamp_expected(thr + pi - ri + yi);
		q[2] = clamp_expected(thr - pi - ri - yi);
		q[3] = clamp_expected(thr - pi + ri + yi);
		return q;
	endfunction

	task automatic stop_run();
		errors++;
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic give_up(input string why);
		$display("%s, at %0t ns", why, $time);
		stop_run();
	endtask

	task automatic check_rate(input rate_t got, input rate_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_motor(input motor_t got, input motor_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic draw(output logic [31:0] v);
		stim_state = xorshift32(stim_state);
		v = stim_state;
	endtask

	// fixed ready level, driven on a falling edge
	task automatic set_ready(input logic level);
		@(posedge start_signal);
		ready_random = 1'b0;
		@(negedge start_signal);
		motor_ready = level;
	endtask

	// offer one cycle, wait for acceptance and done, check the rates
	task automatic launch_cycle(input throttle_t thr, input rate_t y_t, input rate_t p_t,
		input rate_t r_t, input rate_t y_a, input rate_t p_a, input rate_t r_a,
		input int max_wait, output bit accepted);
		int waited;
		int latency;
		int ey, ep, er;
		rate_t dut_y, dut_p, dut_r;
		waited = 0;
		latency = 0;
		@(negedge start_signal);
		throttle = thr;
		yaw_target = y_t;
		pitch_target = p_t;
		roll_target = r_t;
		yaw_rotation = y_a;
		pitch_rotation = p_a;
		roll_rotation = r_a;
		cycle_start = 1'b1;
		while (!cycle_ready && waited < max_wait) begin
			@(negedge start_signal);
			waited++;
		end
		accepted = cycle_ready;
		if (!accepted) begin
			cycle_start = 1'b0;
			return;
		end
		// next rising edge takes it, so the model steps now
		ey = model_pid(`KP_YAW, `KI_YAW, y_t, y_a, integ_yaw);
		ep = model_pid(`KP_DEFAULT, `KI_DEFAULT, p_t, p_a, integ_pitch);
		er = model_pid(`KP_DEFAULT, `KI_DEFAULT, r_t, r_a, integ_roll);
		do begin
			@(negedge start_signal);
			cycle_start = 1'b0;
			latency++;
		end while (!cycle_done && latency < 20);
		if (!cycle_done)
			give_up("cycle_done never came after an accepted start");
		if (latency != 5) begin
			$display("FAILED at %0t ns: cycle_done %0d clocks after acceptance, expected 5",
				$time, latency);
			stop_run();
		end
		// rate fields of the entry being pushed
		{dut_y, dut_p, dut_r} = UUT.u_bfc.push_data[`ENTRY_BIT_WIDTH-1:`THROTTLE_BIT_WIDTH];
		check_rate(dut_y, rate_t'(ey), "yaw rate");
		check_rate(dut_p, rate_t'(ep), "pitch rate");
		check_rate(dut_r, rate_t'(er), "roll rate");
		got_pitch = dut_p;
		expected_q.push_back(expected_motors(thr, ey, ep, er));
	endtask

	task automatic wait_drained(input int max_clocks);
		int n;
		n = 0;
		while ((expected_q.size() != 0 || motor_valid) && n < max_clocks) begin
			@(negedge start_signal);
			n++;
		end
		if (expected_q.size() != 0 || motor_valid)
			give_up("motor outputs did not drain");
	endtask

	task automatic after_reset();
		@(negedge start_signal);
		if (cycle_ready !== 1'b1 || motor_valid !== 1'b0) begin
			$display("FAILED at %0t ns: after reset cycle_ready=%b motor_valid=%b",
				$time, cycle_ready, motor_valid);
			stop_run();
		end
	endtask

	task automatic single_step();
		bit ok;
		set_ready(1'b1);
		launch_cycle(12'd2000, 16'sd160, -16'sd80, 16'sd320, 16'sd0, 16'sd48, 16'sd0, 20, ok);
		if (!ok)
			give_up("single step cycle was not accepted");
		wait_drained(50);
	endtask

	task automatic integral_buildup();
		bit ok;
		rate_t hist[6];
		rate_t held;
		// pitch error 3000 with the integral pinned at its limit
		held = rate_t'((int'(`KP_DEFAULT) * 3000 + int'(`KI_DEFAULT) * `INTEG_LIMIT)
			>>> `GAIN_SHIFT);
		for (int i = 0; i < 6; i++) begin
			launch_cycle(12'd1800, 16'sd0, 16'sd3000, -16'sd1200, -16'sd400, 16'sd0, 16'sd0,
				20, ok);
			if (!ok)
				give_up("integral cycle was not accepted");
			hist[i] = got_pitch;
		end
		// pitch integral reaches the limit on the third step
		for (int i = 1; i < 6; i++) begin
			if (i < 3 && hist[i] <= hist[i-1]) begin
				$display("FAILED at %0t ns: pitch rate %0d did not rise above %0d",
					$time, hist[i], hist[i-1]);
				stop_run();
			end
			if (i >= 2)
				check_rate(hist[i], held, "pitch rate at integral limit");
		end
		wait_drained(50);
	endtask

	task automatic rate_saturation();
		bit ok;
		// errors beyond 16 bits on every axis
		launch_cycle(12'd0, 16'sh8000, 16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh8000, 16'sh8000,
			20, ok);
		if (!ok)
			give_up("low throttle saturation cycle was not accepted");
		wait_drained(50);
		check_motor(last_motor[2], '0, "rear right at low clamp");
		launch_cycle(12'd4095, 16'sh8000, 16'sh7fff, 16'sh7fff, 16'sh7fff, 16'sh8000,
			16'sh8000, 20, ok);
		if (!ok)
			give_up("high throttle saturation cycle was not accepted");
		wait_drained(50);
		check_motor(last_motor[0], motor_t'(`MOTOR_MAX), "front left at high clamp");
	endtask

	task automatic backpressure();
		bit ok;
		set_ready(1'b0);
		// fifo entries plus the mixer output register
		for (int i = 0; i < `FIFO_DEPTH + 1; i++) begin
			launch_cycle(throttle_t'(1000 + 200 * i), rate_t'(40 * i), rate_t'(-64 * i),
				rate_t'(96 * i), 16'sd16, rate_t'(8 * i), -16'sd32, 20, ok);
			if (!ok)
				give_up("cycle refused before the FIFO was full");
		end
		launch_cycle(12'd500, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 16'sd0, 20, ok);
		if (ok)
			give_up("cycle accepted while the FIFO was full");
		if (cycle_ready !== 1'b0 || motor_valid !== 1'b1) begin
			$display("FAILED at %0t ns: under stall cycle_ready=%b motor_valid=%b",
				$time, cycle_ready, motor_valid);
			stop_run();
		end
		set_ready(1'b1);
		wait_drained(100);
	endtask

	task automatic random_run();
		bit ok;
		logic [31:0] a, b, c, d;
		@(posedge start_signal);
		ready_random = 1'b1;
		for (int i = 0; i < 40; i++) begin
			draw(a);
			draw(b);
			draw(c);
			draw(d);
			launch_cycle(a[11:0], a[31:16], b[15:0], b[31:16], c[15:0], c[31:16], d[15:0],
				100, ok);
			if (!ok)
				give_up("random cycle was never accepted");
		end
		set_ready(1'b1);
		wait_drained(200);
	endtask

	// takes every transfer, in order, against the model queue
	always @(posedge start_signal) begin : output_monitor
		motor_quad_t exp_m;
		if (resetn && motor_valid && motor_ready) begin
			if (expected_q.size() == 0) begin
				give_up("motor output transferred with no cycle pending");
			end else begin
				exp_m = expected_q.pop_front();
				check_motor(motor0, exp_m[0], "motor0");
				check_motor(motor1, exp_m[1], "motor1");
				check_motor(motor2, exp_m[2], "motor2");
				check_motor(motor3, exp_m[3], "motor3");
				// words actually handed over
				last_motor = {motor3, motor2, motor1, motor0};
			end
		end
	end

	// random ready, own state so stimulus order stays fixed
	initial begin : ready_driver
		motor_ready = 1'b0;
		ready_random = 1'b0;
		ready_state = SEED ^ 32'h2545f491;
		forever begin
			@(negedge start_signal);
			if (ready_random) begin
				ready_state = xorshift32(ready_state);
				motor_ready = ready_state[3];
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		give_up("watchdog expired before the tests finished");
	end

	initial begin
		errors = 0;
		integ_yaw = 0;
		integ_pitch = 0;
		integ_roll = 0;
		stim_state = SEED;
		resetn = 1'b0;
		cycle_start = 1'b0;
		throttle = '0;
		yaw_target = '0;
		pitch_target = '0;
		roll_target = '0;
		yaw_rotation = '0;
		pitch_rotation = '0;
		roll_rotation = '0;
		repeat (3) @(posedge start_signal);
		@(negedge start_signal);
		resetn = 1'b1;
		after_reset();
		single_step();
		integral_buildup();
		rate_saturation();
		backpressure();
		random_run();
		if (errors == 0 && UUT.u_checker.fail_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- rate_controller_top.f
+incdir+source
source/flight_pkg.sv
source/pid.sv
source/body_frame_controller.sv
source/rate_fifo.sv
source/motor_mixer.sv
source/rate_controller_top.sv
tests/rate_controller_checker.sv
tests/rate_controller_tb.sv
